// File: isa_pkg.sv
package isa_pkg;

    localparam int DATA_W   = 16;
    localparam int NUM_REGS = 16;

    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_XOR = 4'h3,
        OP_LDI = 4'h4,
        OP_MUL = 4'h5
    } opcode_e;

    // ldi takes its immediate from the rs1 and rs2 fields.
    typedef struct packed {
        opcode_e    op;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
    } instr_t;

    function automatic logic [DATA_W-1:0] exec_result(opcode_e op, logic [DATA_W-1:0] a,
                                                      logic [DATA_W-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;   // low half of the product.
            default: return a;       // ldi passes the immediate through.
        endcase
    endfunction

endpackage

// File: core_pkg.sv
package core_pkg;

    localparam int ROB_DEPTH_DEF = 8;

    localparam logic [7:0] APB_INSTR_ADDR  = 8'h00;
    localparam logic [7:0] APB_STATUS_ADDR = 8'h04;

    typedef enum logic [1:0] {
        SLOT_FREE,
        SLOT_WAIT,
        SLOT_READY
    } slot_state_e;

endpackage

// File: reg_alias_table.sv
`timescale 1ns/1ps

module reg_alias_table
    import isa_pkg::*;
#(
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
)
(
    input  logic              clk1,
    input  logic              rst_n,
    input  logic [3:0]        rat_rs1,
    input  logic [3:0]        rat_rs2,
    input  logic [3:0]        rat_rd,
    input  logic              rat_alloc,
    input  logic [TAG_W-1:0]  rat_alloc_tag,
    input  logic              commit_valid,
    input  logic [3:0]        commit_rd,
    input  logic [TAG_W-1:0]  commit_tag,
    input  logic [DATA_W-1:0] commit_value,
    output logic              rs1_busy,
    output logic [TAG_W-1:0]  rs1_tag,
    output logic [DATA_W-1:0] rs1_value,
    output logic              rs2_busy,
    output logic [TAG_W-1:0]  rs2_tag,
    output logic [DATA_W-1:0] rs2_value
);

    logic [DATA_W-1:0]   reg_value [NUM_REGS];
    logic [TAG_W-1:0]    reg_tag [NUM_REGS];
    logic [NUM_REGS-1:0] reg_busy;

    always_ff @(posedge clk1)
    begin
        if (!rst_n)
        begin
            reg_busy <= '0;
            for (int i = 0; i < NUM_REGS; i++)
                reg_value[i] <= '0;
        end
        else
        begin
            if (commit_valid)
            begin
                reg_value[commit_rd] <= commit_value;
                if (reg_tag[commit_rd] == commit_tag)   // only the latest writer releases.
                    reg_busy[commit_rd] <= 1'b0;
            end
            if (rat_alloc)   // a rename in the same cycle overrides the commit.
                reg_busy[rat_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk1)
    begin
        if (rat_alloc)
            reg_tag[rat_rd] <= rat_alloc_tag;
    end

    assign rs1_busy  = reg_busy[rat_rs1];
    assign rs1_tag   = reg_tag[rat_rs1];
    assign rs1_value = reg_value[rat_rs1];
    assign rs2_busy  = reg_busy[rat_rs2];
    assign rs2_tag   = reg_tag[rat_rs2];
    assign rs2_value = reg_value[rat_rs2];

endmodule

// File: reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer
    import isa_pkg::*;
#(
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
)
(
    input  logic              clk1,
    input  logic              rst_n,
    input  logic              rob_alloc,
    input  logic [3:0]        rob_alloc_rd,
    input  logic              cdb_valid,
    input  logic [TAG_W-1:0]  cdb_tag,
    input  logic [DATA_W-1:0] cdb_value,
    input  logic [TAG_W-1:0]  rob_query_tag1,
    input  logic [TAG_W-1:0]  rob_query_tag2,
    output logic [TAG_W-1:0]  rob_tail,
    output logic [TAG_W:0]    rob_count,
    output logic              rob_full,
    output logic              query1_ready,
    output logic [DATA_W-1:0] query1_value,
    output logic              query2_ready,
    output logic [DATA_W-1:0] query2_value,
    output logic              commit_valid,
    output logic [3:0]        commit_rd,
    output logic [TAG_W-1:0]  commit_tag,
    output logic [DATA_W-1:0] commit_value
);

    logic [3:0]           ent_rd [ROB_DEPTH];
    logic [DATA_W-1:0]    ent_value [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_done;
    logic [TAG_W-1:0]     head;

    always_ff @(posedge clk1)
    begin
        if (!rst_n)
        begin
            head      <= '0;
            rob_tail  <= '0;
            rob_count <= '0;
            ent_done  <= '0;
        end
        else
        begin
            if (rob_alloc)
            begin
                ent_done[rob_tail] <= 1'b0;
                rob_tail           <= rob_tail + 1'b1;   // wraps, depth is a power of two.
            end
            if (cdb_valid)
                ent_done[cdb_tag] <= 1'b1;
            if (commit_valid)
                head <= head + 1'b1;
            case ({rob_alloc, commit_valid})
                2'b10:   rob_count <= rob_count + 1'b1;
                2'b01:   rob_count <= rob_count - 1'b1;
                default: rob_count <= rob_count;
            endcase
        end
    end

    always_ff @(posedge clk1)
    begin
        if (rob_alloc)
            ent_rd[rob_tail] <= rob_alloc_rd;
        if (cdb_valid)
            ent_value[cdb_tag] <= cdb_value;
    end

    assign rob_full = rob_count == (TAG_W+1)'(ROB_DEPTH);

    // completed but not yet committed results, read by the issue stage.
    assign query1_ready = ent_done[rob_query_tag1];
    assign query1_value = ent_value[rob_query_tag1];
    assign query2_ready = ent_done[rob_query_tag2];
    assign query2_value = ent_value[rob_query_tag2];

    assign commit_valid = (rob_count != '0) && ent_done[head];
    assign commit_rd    = ent_rd[head];
    assign commit_tag   = head;
    assign commit_value = ent_value[head];

endmodule

// File: reservation_station.sv
`timescale 1ns/1ps

module reservation_station
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int  RS_DEPTH     = 3,
    parameter int  EXEC_LATENCY = 1,
    parameter int  ROB_DEPTH    = 8,
    localparam int TAG_W        = $clog2(ROB_DEPTH),
    localparam int AGE_W        = $clog2(RS_DEPTH + 1)
)
(
    input  logic              clk1,
    input  logic              rst_n,
    input  logic              dispatch,
    input  opcode_e           dispatch_op,
    input  logic              src1_ready,
    input  logic [TAG_W-1:0]  src1_tag,
    input  logic [DATA_W-1:0] src1_value,
    input  logic              src2_ready,
    input  logic [TAG_W-1:0]  src2_tag,
    input  logic [DATA_W-1:0] src2_value,
    input  logic [TAG_W-1:0]  dispatch_tag,
    input  logic              cdb_valid,
    input  logic [TAG_W-1:0]  cdb_tag,
    input  logic [DATA_W-1:0] cdb_value,
    input  logic              grant,
    output logic              slot_free,
    output logic              req,
    output logic [TAG_W-1:0]  req_tag,
    output logic [DATA_W-1:0] req_value
);

    slot_state_e       state [RS_DEPTH];
    opcode_e           op [RS_DEPTH];
    logic [TAG_W-1:0]  tag1 [RS_DEPTH];
    logic [TAG_W-1:0]  tag2 [RS_DEPTH];
    logic [TAG_W-1:0]  dest [RS_DEPTH];
    logic [DATA_W-1:0] val1 [RS_DEPTH];
    logic [DATA_W-1:0] val2 [RS_DEPTH];
    logic [AGE_W-1:0]  age [RS_DEPTH];   // number of older occupied slots.
    logic [RS_DEPTH-1:0] rdy1, rdy2, cap1, cap2;

    logic [EXEC_LATENCY-1:0] pipe_valid;
    logic [TAG_W-1:0]        pipe_tag [EXEC_LATENCY];
    logic [DATA_W-1:0]       pipe_value [EXEC_LATENCY];

    logic             advance;
    logic             fire;
    int               fire_idx;
    int               free_idx;
    logic [AGE_W-1:0] occupied;

    assign advance = !pipe_valid[EXEC_LATENCY-1] || grant;

    always_comb
    begin
        fire      = 1'b0;
        fire_idx  = 0;
        free_idx  = 0;
        slot_free = 1'b0;
        occupied  = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--)
        begin
            cap1[i] = (state[i] == SLOT_WAIT) && !rdy1[i] && cdb_valid && (cdb_tag == tag1[i]);
            cap2[i] = (state[i] == SLOT_WAIT) && !rdy2[i] && cdb_valid && (cdb_tag == tag2[i]);
            if (state[i] == SLOT_FREE)
            begin
                slot_free = 1'b1;
                free_idx  = i;   // lowest free slot.
            end
            else
                occupied = occupied + 1'b1;
            if (state[i] == SLOT_READY && (!fire || age[i] < age[fire_idx]))
            begin
                fire     = 1'b1;
                fire_idx = i;
            end
        end
        fire = fire && advance;   // oldest ready slot, only when the pipe moves.
    end

    always_ff @(posedge clk1)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < RS_DEPTH; i++)
                state[i] <= SLOT_FREE;
        end
        else
        begin
            for (int i = 0; i < RS_DEPTH; i++)
            begin
                if (dispatch && i == free_idx)
                    state[i] <= (src1_ready && src2_ready) ? SLOT_READY : SLOT_WAIT;
                else if (fire && i == fire_idx)
                    state[i] <= SLOT_FREE;
                else if (state[i] == SLOT_WAIT && (rdy1[i] || cap1[i]) && (rdy2[i] || cap2[i]))
                    state[i] <= SLOT_READY;
            end
        end
    end

    always_ff @(posedge clk1)
    begin
        for (int i = 0; i < RS_DEPTH; i++)
        begin
            if (cap1[i])
            begin
                rdy1[i] <= 1'b1;
                val1[i] <= cdb_value;
            end
            if (cap2[i])
            begin
                rdy2[i] <= 1'b1;
                val2[i] <= cdb_value;
            end
            if (fire && state[i] != SLOT_FREE && age[i] > age[fire_idx])
                age[i] <= age[i] - 1'b1;
            if (dispatch && i == free_idx)
            begin
                op[i]   <= dispatch_op;
                rdy1[i] <= src1_ready;
                tag1[i] <= src1_tag;
                val1[i] <= src1_value;
                rdy2[i] <= src2_ready;
                tag2[i] <= src2_tag;
                val2[i] <= src2_value;
                dest[i] <= dispatch_tag;
                age[i]  <= occupied - AGE_W'(fire);
            end
        end
    end

    always_ff @(posedge clk1)
    begin
        if (!rst_n)
            pipe_valid <= '0;
        else if (advance)
        begin
            pipe_valid[0] <= fire;
            for (int s = 1; s < EXEC_LATENCY; s++)
                pipe_valid[s] <= pipe_valid[s-1];
        end
    end

    // result is computed on entry and then carried down the stages.
    always_ff @(posedge clk1)
    begin
        if (advance)
        begin
            pipe_tag[0]   <= dest[fire_idx];
            pipe_value[0] <= exec_result(op[fire_idx], val1[fire_idx], val2[fire_idx]);
            for (int s = 1; s < EXEC_LATENCY; s++)
            begin
                pipe_tag[s]   <= pipe_tag[s-1];
                pipe_value[s] <= pipe_value[s-1];
            end
        end
    end

    assign req       = pipe_valid[EXEC_LATENCY-1];
    assign req_tag   = pipe_tag[EXEC_LATENCY-1];
    assign req_value = pipe_value[EXEC_LATENCY-1];

endmodule

// File: cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter
    import isa_pkg::*;
#(
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
)
(
    input  logic              clk1,
    input  logic              rst_n,
    input  logic              add_req,
    input  logic [TAG_W-1:0]  add_tag,
    input  logic [DATA_W-1:0] add_value,
    input  logic              mul_req,
    input  logic [TAG_W-1:0]  mul_tag,
    input  logic [DATA_W-1:0] mul_value,
    output logic              add_grant,
    output logic              mul_grant,
    output logic              cdb_valid,
    output logic [TAG_W-1:0]  cdb_tag,
    output logic [DATA_W-1:0] cdb_value
);

    logic last_mul;   // multiplier won the last grant.

    assign add_grant = add_req && (!mul_req || last_mul);
    assign mul_grant = mul_req && !add_grant;

    always_ff @(posedge clk1)
    begin
        if (!rst_n)
            last_mul <= 1'b0;
        else if (add_grant || mul_grant)
            last_mul <= mul_grant;
    end

    assign cdb_valid = add_grant || mul_grant;
    assign cdb_tag   = mul_grant ? mul_tag : add_tag;
    assign cdb_value = mul_grant ? mul_value : add_value;

endmodule

// File: issue_unit.sv
`timescale 1ns/1ps

module issue_unit
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
)
(
    input  logic [7:0]        paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic [3:0]        rat_rs1,
    output logic [3:0]        rat_rs2,
    output logic [3:0]        rat_rd,
    output logic              rat_alloc,
    input  logic              rs1_busy,
    input  logic [TAG_W-1:0]  rs1_tag,
    input  logic [DATA_W-1:0] rs1_value,
    input  logic              rs2_busy,
    input  logic [TAG_W-1:0]  rs2_tag,
    input  logic [DATA_W-1:0] rs2_value,
    output logic [TAG_W-1:0]  rob_query_tag1,
    output logic [TAG_W-1:0]  rob_query_tag2,
    input  logic              query1_ready,
    input  logic [DATA_W-1:0] query1_value,
    input  logic              query2_ready,
    input  logic [DATA_W-1:0] query2_value,
    output logic              rob_alloc,
    output logic [3:0]        rob_alloc_rd,
    input  logic [TAG_W-1:0]  rob_tail,
    input  logic [TAG_W:0]    rob_count,
    input  logic              rob_full,
    input  logic              cdb_valid,
    input  logic [TAG_W-1:0]  cdb_tag,
    input  logic [DATA_W-1:0] cdb_value,
    input  logic              add_slot_free,
    input  logic              mul_slot_free,
    output logic              add_dispatch,
    output logic              mul_dispatch,
    output opcode_e           dispatch_op,
    output logic              src1_ready,
    output logic [TAG_W-1:0]  src1_tag,
    output logic [DATA_W-1:0] src1_value,
    output logic              src2_ready,
    output logic [TAG_W-1:0]  src2_tag,
    output logic [DATA_W-1:0] src2_value,
    output logic [TAG_W-1:0]  dispatch_tag
);

    instr_t          instr;
    logic            is_mul;
    logic            is_ldi;
    logic            instr_wr;
    logic            stall;
    logic            issue;
    logic [DATA_W:0] opnd1;   // ready bit above the value.
    logic [DATA_W:0] opnd2;

    // register file, then finished rob entry, then the bus this cycle.
    function automatic logic [DATA_W:0] resolve(logic busy, logic [TAG_W-1:0] tag,
                                                logic [DATA_W-1:0] reg_val, logic rob_rdy,
                                                logic [DATA_W-1:0] rob_val, logic bus_valid,
                                                logic [TAG_W-1:0] bus_tag,
                                                logic [DATA_W-1:0] bus_val);
        if (!busy)
            return {1'b1, reg_val};
        if (rob_rdy)
            return {1'b1, rob_val};
        if (bus_valid && bus_tag == tag)
            return {1'b1, bus_val};
        return '0;
    endfunction

    assign instr    = instr_t'(pwdata);
    assign is_mul   = instr.op == OP_MUL;
    assign is_ldi   = instr.op == OP_LDI;
    assign instr_wr = psel && penable && pwrite && (paddr == APB_INSTR_ADDR);
    assign stall    = rob_full || (is_mul ? !mul_slot_free : !add_slot_free);
    assign issue    = instr_wr && !stall;

    assign pready = psel && penable && !(instr_wr && stall);
    assign prdata = (paddr == APB_STATUS_ADDR) ? DATA_W'(rob_count) : '0;

    assign rat_rs1        = instr.rs1;
    assign rat_rs2        = instr.rs2;
    assign rat_rd         = instr.rd;
    assign rat_alloc      = issue;
    assign rob_query_tag1 = rs1_tag;
    assign rob_query_tag2 = rs2_tag;
    assign rob_alloc      = issue;
    assign rob_alloc_rd   = instr.rd;

    assign opnd1 = resolve(rs1_busy, rs1_tag, rs1_value, query1_ready, query1_value,
                           cdb_valid, cdb_tag, cdb_value);
    assign opnd2 = resolve(rs2_busy, rs2_tag, rs2_value, query2_ready, query2_value,
                           cdb_valid, cdb_tag, cdb_value);

    assign add_dispatch = issue && !is_mul;
    assign mul_dispatch = issue && is_mul;
    assign dispatch_op  = instr.op;
    assign dispatch_tag = rob_tail;
    assign src1_ready   = is_ldi || opnd1[DATA_W];
    assign src1_tag     = rs1_tag;
    assign src1_value   = is_ldi ? DATA_W'({instr.rs1, instr.rs2}) : opnd1[DATA_W-1:0];
    assign src2_ready   = is_ldi || opnd2[DATA_W];
    assign src2_tag     = rs2_tag;
    assign src2_value   = opnd2[DATA_W-1:0];

endmodule

// File: tomasulo_core.sv
`timescale 1ns/1ps

module tomasulo_core
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int  ROB_DEPTH   = ROB_DEPTH_DEF,
    parameter int  RS_DEPTH    = 3,
    parameter int  MUL_LATENCY = 3,
    parameter int  ADD_LATENCY = 1,
    localparam int TAG_W       = $clog2(ROB_DEPTH)
)
(
    input  logic              clk1,
    input  logic              rst_n,
    input  logic [7:0]        paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              commit_valid,
    output logic [3:0]        commit_rd,
    output logic [DATA_W-1:0] commit_value
);

    logic [3:0]        rat_rs1, rat_rs2, rat_rd;
    logic              rat_alloc;
    logic              rs1_busy, rs2_busy;
    logic [TAG_W-1:0]  rs1_tag, rs2_tag;
    logic [DATA_W-1:0] rs1_value, rs2_value;
    logic [TAG_W-1:0]  rob_query_tag1, rob_query_tag2;
    logic              query1_ready, query2_ready;
    logic [DATA_W-1:0] query1_value, query2_value;
    logic              rob_alloc;
    logic [3:0]        rob_alloc_rd;
    logic [TAG_W-1:0]  rob_tail;
    logic [TAG_W:0]    rob_count;
    logic              rob_full;
    logic [TAG_W-1:0]  commit_tag;
    logic              cdb_valid;
    logic [TAG_W-1:0]  cdb_tag;
    logic [DATA_W-1:0] cdb_value;
    logic              add_dispatch, mul_dispatch;
    opcode_e           dispatch_op;
    logic              src1_ready, src2_ready;
    logic [TAG_W-1:0]  src1_tag, src2_tag, dispatch_tag;
    logic [DATA_W-1:0] src1_value, src2_value;
    logic              add_slot_free, mul_slot_free;
    logic              add_req, mul_req, add_grant, mul_grant;
    logic [TAG_W-1:0]  add_tag, mul_tag;
    logic [DATA_W-1:0] add_value, mul_value;

    issue_unit #(.ROB_DEPTH(ROB_DEPTH)) i_issue (.*);

    reg_alias_table #(.ROB_DEPTH(ROB_DEPTH)) i_rat (
        .rat_alloc_tag (rob_tail),
        .*
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) i_rob (.*);

    reservation_station #(
        .RS_DEPTH     (RS_DEPTH),
        .EXEC_LATENCY (ADD_LATENCY),
        .ROB_DEPTH    (ROB_DEPTH)
    ) i_add_rs (
        .dispatch  (add_dispatch),
        .grant     (add_grant),
        .slot_free (add_slot_free),
        .req       (add_req),
        .req_tag   (add_tag),
        .req_value (add_value),
        .*
    );

    reservation_station #(
        .RS_DEPTH     (RS_DEPTH),
        .EXEC_LATENCY (MUL_LATENCY),
        .ROB_DEPTH    (ROB_DEPTH)
    ) i_mul_rs (
        .dispatch  (mul_dispatch),
        .grant     (mul_grant),
        .slot_free (mul_slot_free),
        .req       (mul_req),
        .req_tag   (mul_tag),
        .req_value (mul_value),
        .*
    );

    cdb_arbiter #(.ROB_DEPTH(ROB_DEPTH)) i_cdb_arb (.*);

endmodule

// File: tb_tomasulo.sv
`timescale 1ns/1ps

module tb_tomasulo
    import isa_pkg::*;
    import core_pkg::*;
;

    localparam int          PREADY_TIMEOUT = 200;
    localparam int          DRAIN_TIMEOUT  = 100;
    localparam int          WATCHDOG       = 200000;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic        clk1;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        commit_valid;
    logic [3:0]  commit_rd;
    logic [15:0] commit_value;

    logic [15:0] model_regs [16];
    logic [3:0]  exp_rd [$];
    logic [15:0] exp_val [$];
    logic [31:0] lfsr;
    int          stall_cycles;

    tomasulo_core i_dut (.*);

    initial
    begin
        clk1 = 1'b0;
        forever #2 clk1 = ~clk1;
    end

    task automatic value_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    // one lfsr step per bit taken.
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic apb_write(input logic [7:0] addr, input logic [15:0] data);
        int waited;
        waited = 0;
        @(posedge clk1);
        #0.5;
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk1);
        #0.5;
        penable = 1'b1;
        @(negedge clk1);
        while (!pready)
        begin
            stall_cycles++;
            waited++;
            if (waited > PREADY_TIMEOUT)
                abort_run("timed out waiting for pready on an APB write");
            @(negedge clk1);
        end
        @(posedge clk1);   // transfer completes here.
        #0.5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [15:0] data);
        int waited;
        waited = 0;
        @(posedge clk1);
        #0.5;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk1);
        #0.5;
        penable = 1'b1;
        @(negedge clk1);
        while (!pready)
        begin
            waited++;
            if (waited > PREADY_TIMEOUT)
                abort_run("timed out waiting for pready on an APB read");
            @(negedge clk1);
        end
        data = prdata;
        @(posedge clk1);
        #0.5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // reference model runs in program order at issue time.
    task automatic issue_instr(input opcode_e op, input logic [3:0] rd,
                               input logic [3:0] rs1, input logic [3:0] rs2);
        logic [15:0] a;
        logic [15:0] b;
        logic [31:0] prod;
        logic [15:0] result;
        a    = model_regs[rs1];
        b    = model_regs[rs2];
        prod = a * b;
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_XOR:  result = a ^ b;
            OP_MUL:  result = prod[15:0];
            OP_LDI:  result = {8'h00, rs1, rs2};
            default: result = '0;
        endcase
        model_regs[rd] = result;
        exp_rd.push_back(rd);
        exp_val.push_back(result);
        apb_write(APB_INSTR_ADDR, {op, rd, rs1, rs2});
    endtask

    task automatic issue_ldi(input logic [3:0] rd, input logic [7:0] imm);
        issue_instr(OP_LDI, rd, imm[7:4], imm[3:0]);
    endtask

    task automatic drain_core();
        logic [15:0] occ;
        int          polls;
        polls = 0;
        apb_read(APB_STATUS_ADDR, occ);
        while (occ != 16'd0)
        begin
            polls++;
            if (polls > DRAIN_TIMEOUT)
                abort_run("reorder buffer did not drain");
            apb_read(APB_STATUS_ADDR, occ);
        end
        assert (exp_rd.size() == 0)
        else abort_run("buffer drained with commits still missing");
    endtask

    function automatic opcode_e pick_op(input logic [15:0] sel);
        case (sel % 6)
            0:       return OP_ADD;
            1:       return OP_SUB;
            2:       return OP_AND;
            3:       return OP_XOR;
            4:       return OP_LDI;
            default: return OP_MUL;
        endcase
    endfunction

    // every commit must match the oldest outstanding instruction.
    always @(negedge clk1)
    begin
        if (rst_n && commit_valid)
        begin
            assert (exp_rd.size() > 0)
            else abort_run("commit seen with no instruction outstanding");
            assert (commit_rd == exp_rd[0] && commit_value == exp_val[0])
            else value_error($sformatf("commit r%0d=%h, expected r%0d=%h",
                                       commit_rd, commit_value, exp_rd[0], exp_val[0]));
            exp_rd.pop_front();
            exp_val.pop_front();
        end
    end

    initial
    begin
        repeat (WATCHDOG) @(posedge clk1);
        abort_run("simulation watchdog expired");
    end

    initial
    begin
        logic [15:0] status;
        opcode_e     op;
        rst_n        = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        lfsr         = 32'hda72;
        stall_cycles = 0;
        for (int i = 0; i < 16; i++)
            model_regs[i] = '0;
        repeat (10) @(posedge clk1);
        #0.5;
        rst_n = 1'b1;

        $display("reset state");
        @(negedge clk1);
        assert (!commit_valid)
        else value_error("commit_valid high after reset");
        apb_read(APB_STATUS_ADDR, status);
        assert (status == 16'd0)
        else value_error($sformatf("status %0d after reset", status));

        $display("load immediates");
        issue_ldi(4'd1, 8'h0a);
        issue_ldi(4'd2, 8'h03);
        issue_ldi(4'd3, 8'hff);
        issue_ldi(4'd4, 8'h5c);
        drain_core();

        $display("dependent alu chain");
        issue_instr(OP_ADD, 4'd5, 4'd1, 4'd2);
        issue_instr(OP_SUB, 4'd6, 4'd5, 4'd3);
        issue_instr(OP_AND, 4'd7, 4'd6, 4'd4);
        issue_instr(OP_XOR, 4'd8, 4'd7, 4'd6);
        issue_instr(OP_ADD, 4'd5, 4'd8, 4'd5);   // second writer of r5.
        issue_instr(OP_SUB, 4'd9, 4'd5, 4'd5);
        drain_core();

        $display("multiply with independent adds");
        issue_instr(OP_MUL, 4'd15, 4'd3, 4'd4);
        issue_instr(OP_MUL, 4'd15, 4'd15, 4'd4);
        issue_instr(OP_MUL, 4'd12, 4'd15, 4'd4);  // waits on the chain above.
        issue_instr(OP_ADD, 4'd10, 4'd1, 4'd2);   // completes before the multiply.
        issue_instr(OP_ADD, 4'd12, 4'd1, 4'd1);   // newer writer of r12.
        issue_instr(OP_ADD, 4'd13, 4'd12, 4'd2);  // issued between the two r12 commits.
        issue_instr(OP_XOR, 4'd11, 4'd3, 4'd1);
        drain_core();
        issue_instr(OP_ADD, 4'd14, 4'd12, 4'd0); // reads the committed register.
        drain_core();

        $display("multiply burst");
        stall_cycles = 0;
        for (int i = 0; i < 10; i++)
            issue_instr(OP_MUL, 4'd1, 4'd1, 4'd2);
        for (int i = 0; i < 6; i++)
            issue_instr(OP_ADD, 4'(i + 2), 4'd1, 4'd3);
        assert (stall_cycles > 0)
        else abort_run("pready never went low during the multiply burst");
        drain_core();

        $display("random program");
        for (int i = 0; i < 200; i++)
        begin
            op = pick_op(rand_bits(3));
            issue_instr(op, 4'(rand_bits(4)), 4'(rand_bits(4)), 4'(rand_bits(4)));
        end
        drain_core();

        if (exp_rd.size() != 0)
            abort_run("expected commits still pending at the end");
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: vlog.f
isa_pkg.sv
core_pkg.sv
reg_alias_table.sv
reorder_buffer.sv
reservation_station.sv
cdb_arbiter.sv
issue_unit.sv
tomasulo_core.sv
tb_tomasulo.sv
